// File: source/divSqrtPkg.sv
// Types shared by the SRT divide and square-root unit
// The step-control bundle holds no width that depends on N
// Remainder and quotient words travel as plain ports sized by N
package divSqrtPkg;

  // Operation select, latched by the controller at start
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } opKind_t;

  // Radix-2 signed quotient digit from the set {-1, 0, +1}
  // Code 2'b10 is never produced by the digit selection
  typedef enum logic [1:0] {
    DIGIT_ZERO = 2'b00,
    DIGIT_POS  = 2'b01,
    DIGIT_NEG  = 2'b11
  } qDigit_t;

  // Per-cycle control from the sequencer to the datapath blocks
  typedef struct packed {
    // Operation of the running request
    opKind_t op;
    // High in the cycle whose closing edge initializes the datapath
    logic    load;
    // High in every iteration cycle
    logic    step;
    // High on the final iteration only
    logic    lastStep;
  } stepCtrl_t;

endpackage

// File: source/divSqrtCtrl.sv
// Sequencer for the fixed-latency divider and square-root unit
// One load cycle is followed by N+2 iteration cycles
// A start is ignored while busy is high
module divSqrtCtrl #(
  parameter int N = 24
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  start,
  input  divSqrtPkg::opKind_t   op,
  output logic                  busy,
  output logic                  done,
  output divSqrtPkg::stepCtrl_t stepCtrl
);

  // Counter must reach N+1, the index of the last iteration
  localparam int CW = $clog2(N + 3);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    LOAD    = 2'b01,
    ITERATE = 2'b10
  } ctrlState_t;

  ctrlState_t          state;
  logic [CW-1:0]       stepCnt;
  divSqrtPkg::opKind_t opReg;
  logic                lastNow;

  // Final iteration is the one whose count equals N+1
  assign lastNow = (state == ITERATE) && (stepCnt == CW'(N + 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= IDLE;
      stepCnt <= '0;
      opReg   <= divSqrtPkg::OP_DIV;
      done    <= 1'b0;
    end else begin
      // done is a single pulse in the cycle after the last step
      done <= lastNow;
      case (state)
        IDLE: begin
          if (start) begin
            state <= LOAD;
            opReg <= op;
          end
        end
        LOAD: begin
          state   <= ITERATE;
          stepCnt <= '0;
        end
        ITERATE: begin
          if (lastNow) begin
            state <= IDLE;
          end else begin
            stepCnt <= stepCnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // All outputs decode registered state only
  assign busy              = (state != IDLE);
  assign stepCtrl.op       = opReg;
  assign stepCtrl.load     = (state == LOAD);
  assign stepCtrl.step     = (state == ITERATE);
  assign stepCtrl.lastStep = lastNow;

  //////////////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////////////

  // done never stretches over two cycles
  assert property (@(posedge clk) disable iff (!rstN) done |=> !done);

  // Every done pulse closes a full run of N+2 steps after its load cycle
  assert property (@(posedge clk) disable iff (!rstN) done |-> $past(stepCtrl.load, N + 3));

  // A start during a running operation never restarts the sequence
  assert property (@(posedge clk) disable iff (!rstN)
    (start && busy) |=> (state != LOAD));

endmodule

// File: source/divSqrtIter.sv
// Carry-save partial remainder of the radix-2 SRT recurrence
// Remainder format is two's complement with 4 integer and N+2 fraction bits
// Division expects both operands with the leading one set
// Square root expects a radicand in [1,4) as U2.(N-2)
module divSqrtIter #(
  parameter int N = 24
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [N-1:0]          x,
  input  logic [N-1:0]          d,
  input  divSqrtPkg::stepCtrl_t stepCtrl,
  input  logic [N+1:0]          u,
  input  logic [N+1:0]          um,
  input  logic [N+1:0]          c,
  output divSqrtPkg::qDigit_t   digit,
  output logic [N+5:0]          ws,
  output logic [N+5:0]          wc,
  output logic [N-2:0]          dLatched,
  output divSqrtPkg::opKind_t   opLatched
);

  localparam int W = N + 6;

  logic [N-1:0] xHold;
  logic [N-1:0] dHold;
  logic [5:0]   estimate;
  logic [W-1:0] dTerm;
  logic [W-1:0] sqrtPosTerm;
  logic [W-1:0] sqrtNegTerm;
  logic [W-1:0] addTerm;
  logic         carryIn;
  logic [W-1:0] wsShift;
  logic [W-1:0] wcShift;
  logic [W-1:0] csaSum;
  logic [W-1:0] csaMaj;
  logic [W-1:0] csaCarry;
  logic [W-1:0] wsInit;
  logic [W-1:0] wcInit;
  logic [W-1:0] wSum;

  //////////////////////////////////////////////////////////////////////
  // Digit selection
  //////////////////////////////////////////////////////////////////////

  // Top six bits of each word give 2w with one fraction bit
  // Truncation keeps the estimate within one unit below the true 2w
  assign estimate = ws[W-1:N] + wc[W-1:N];

  always_comb begin
    if (!estimate[5]) begin
      digit = divSqrtPkg::DIGIT_POS;
    end else if (estimate == 6'h3f) begin
      // Estimate of exactly -1/2 sits in the overlap region
      digit = divSqrtPkg::DIGIT_ZERO;
    end else begin
      digit = divSqrtPkg::DIGIT_NEG;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Additive term
  //////////////////////////////////////////////////////////////////////

  // Divisor with its hidden one, aligned to the remainder grid
  assign dTerm = {3'b000, 1'b1, dLatched, 3'b000};

  // Square root subtracts 2S plus the new digit weight for a +1 digit
  assign sqrtPosTerm = {3'b000, u, 1'b0} | {4'b0000, c};

  // For a -1 digit it adds 2S minus the weight, which is 2UM plus three weights
  assign sqrtNegTerm = {3'b000, um, 1'b0} | {3'b000, c, 1'b0} | {4'b0000, c};

  always_comb begin
    addTerm = '0;
    carryIn = 1'b0;
    case (digit)
      divSqrtPkg::DIGIT_POS: begin
        // Negation as inverted term plus one injected at the carry LSB
        addTerm = (opLatched == divSqrtPkg::OP_SQRT) ? ~sqrtPosTerm : ~dTerm;
        carryIn = 1'b1;
      end
      divSqrtPkg::DIGIT_NEG: begin
        addTerm = (opLatched == divSqrtPkg::OP_SQRT) ? sqrtNegTerm : dTerm;
      end
      default: begin
        addTerm = '0;
      end
    endcase
  end

  // w(j+1) = 2w(j) + term through one carry-save row
  assign wsShift  = {ws[W-2:0], 1'b0};
  assign wcShift  = {wc[W-2:0], 1'b0};
  assign csaSum   = wsShift ^ wcShift ^ addTerm;
  assign csaMaj   = (wsShift & wcShift) | (wsShift & addTerm) | (wcShift & addTerm);
  assign csaCarry = {csaMaj[W-2:0], carryIn};

  // Division starts from X/4 so that the quotient lands on the U1.N grid
  // Square root starts from R/4 - 1 with the -1 parked in the carry word
  always_comb begin
    if (stepCtrl.op == divSqrtPkg::OP_SQRT) begin
      wsInit = {4'b0000, xHold, 2'b00};
      wcInit = {4'b1111, {(N + 2){1'b0}}};
    end else begin
      wsInit = {5'b00000, xHold, 1'b0};
      wcInit = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ws        <= '0;
      wc        <= '0;
      opLatched <= divSqrtPkg::OP_DIV;
    end else if (stepCtrl.load) begin
      ws        <= wsInit;
      wc        <= wcInit;
      opLatched <= stepCtrl.op;
    end else if (stepCtrl.step) begin
      ws <= csaSum;
      wc <= csaCarry;
    end
  end

  // Operands follow the inputs while idle and freeze at the accepting edge
  // The divisor copy used by the result path only changes on load
  always_ff @(posedge clk) begin
    if (!stepCtrl.load && !stepCtrl.step) begin
      xHold <= x;
      dHold <= d;
    end
    if (stepCtrl.load) begin
      dLatched <= dHold[N-2:0];
    end
  end

  // A converging recurrence keeps the full remainder within [-4,4)
  assign wSum = ws + wc;

  assert property (@(posedge clk) disable iff (!rstN)
    stepCtrl.step |-> (wSum[W-1] == wSum[W-2]));

  // Division operands captured at the accepting edge must be normalized
  assert property (@(posedge clk) disable iff (!rstN)
    (stepCtrl.load && stepCtrl.op == divSqrtPkg::OP_DIV) |-> (xHold[N-1] && dHold[N-1]));

endmodule

// File: source/divSqrtOtf.sv
// On-the-fly conversion of signed digits into U and U minus one ulp
// U holds the result times 2^(N+2) in N+2 bits
// The square-root start value of one sits just above the register
// and is only ever reached again through UM, so it never needs storing
module divSqrtOtf #(
  parameter int N = 24
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  divSqrtPkg::stepCtrl_t stepCtrl,
  input  divSqrtPkg::qDigit_t   digit,
  output logic [N+1:0]          u,
  output logic [N+1:0]          um,
  output logic [N+1:0]          c,
  output logic                  firstUn
);

  // Weight of the first digit is 2^-1, bit N+1 of the register
  localparam logic [N+1:0] C_INIT = {1'b1, {(N + 1){1'b0}}};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      u       <= '0;
      um      <= '0;
      c       <= '0;
      firstUn <= 1'b0;
    end else if (stepCtrl.load) begin
      u       <= '0;
      // UM is minus one ulp for division and zero for the root start of one
      um      <= (stepCtrl.op == divSqrtPkg::OP_SQRT) ? '0 : '1;
      c       <= C_INIT;
      firstUn <= 1'b0;
    end else if (stepCtrl.step) begin
      case (digit)
        divSqrtPkg::DIGIT_POS: begin
          u  <= u | c;
          um <= u;
        end
        divSqrtPkg::DIGIT_NEG: begin
          u  <= um | c;
          um <= um;
        end
        default: begin
          u  <= u;
          um <= um | c;
        end
      endcase
      firstUn <= (digit != divSqrtPkg::DIGIT_ZERO);
      // Mask parks on bit 0 after the final digit as the result ulp
      if (!stepCtrl.lastStep) begin
        c <= c >> 1;
      end
    end
  end

endmodule

// File: source/divSqrtPostproc.sv
// Result correction and alignment, purely combinational
// Inputs must hold their values after the last step for a stable result
module divSqrtPostproc #(
  parameter int N = 24
) (
  input  logic [N+5:0]        ws,
  input  logic [N+5:0]        wc,
  input  logic [N-2:0]        dLatched,
  input  divSqrtPkg::opKind_t op,
  input  logic [N+1:0]        u,
  input  logic [N+1:0]        um,
  input  logic [N+1:0]        c,
  input  logic                firstUn,
  output logic [N:0]          quot,
  output logic                sticky
);

  localparam int W = N + 6;

  logic [W-1:0] wOr;
  logic         weq0;
  logic [W-1:0] fTerm;
  logic [W-1:0] fSum;
  logic [W-1:0] fMaj;
  logic [W-1:0] fCarry;
  logic [W-1:0] fOr;
  logic         wfeq0;
  logic         wZero;
  logic [W-1:0] wFull;
  logic [N+1:0] sel;

  // a + b is zero exactly when a ^ b equals (a | b) shifted left by one
  assign wOr  = ws | wc;
  assign weq0 = ((ws ^ wc) == {wOr[W-2:0], 1'b0});

  // Correction term for a negative remainder
  // Division adds D back and square root adds 2UM plus one ulp
  assign fTerm = (op == divSqrtPkg::OP_SQRT) ?
                 ({3'b000, um, 1'b0} | {4'b0000, c}) :
                 {3'b000, 1'b1, dLatched, 3'b000};

  // Look-ahead: would the corrected remainder be zero
  assign fSum   = ws ^ wc ^ fTerm;
  assign fMaj   = (ws & wc) | (ws & fTerm) | (wc & fTerm);
  assign fCarry = {fMaj[W-2:0], 1'b0};
  assign fOr    = fSum | fCarry;
  assign wfeq0  = ((fSum ^ fCarry) == {fOr[W-2:0], 1'b0});

  // A remainder of exactly minus F can only follow a nonzero last digit
  assign wZero = weq0 | (wfeq0 & firstUn);

  // Sign of the full remainder picks U or U minus one ulp
  assign wFull = ws + wc;
  assign sel   = wFull[W-1] ? um : u;

  // Square root carries one extra fraction bit, dropped here into sticky
  assign quot   = (op == divSqrtPkg::OP_SQRT) ? sel[N+1:1] : sel[N:0];
  assign sticky = ~wZero | ((op == divSqrtPkg::OP_SQRT) & sel[0]);

endmodule

// File: source/divSqrtUnit.sv
// Radix-2 SRT divide and square-root unit for normalized significands
// N must be even; latency is fixed at N+4 cycles from the accepting edge
// Exponents, rounding and special values belong to the surrounding FPU
module divSqrtUnit #(
  parameter int N = 24
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                start,
  input  divSqrtPkg::opKind_t op,
  input  logic [N-1:0]        x,
  input  logic [N-1:0]        d,
  output logic                busy,
  output logic                done,
  output logic [N:0]          quot,
  output logic                sticky
);

  divSqrtPkg::stepCtrl_t stepCtrl;
  divSqrtPkg::qDigit_t   digit;
  divSqrtPkg::opKind_t   opLatched;
  logic [N+1:0]          u;
  logic [N+1:0]          um;
  logic [N+1:0]          c;
  logic                  firstUn;
  logic [N+5:0]          ws;
  logic [N+5:0]          wc;
  logic [N-2:0]          dLatched;

  divSqrtCtrl #(.N(N)) ctrl (
    .clk, .rstN, .start, .op, .busy, .done, .stepCtrl
  );

  divSqrtIter #(.N(N)) iter (
    .clk, .rstN, .x, .d, .stepCtrl, .u, .um, .c,
    .digit, .ws, .wc, .dLatched, .opLatched
  );

  divSqrtOtf #(.N(N)) otf (
    .clk, .rstN, .stepCtrl, .digit, .u, .um, .c, .firstUn
  );

  divSqrtPostproc #(.N(N)) post (
    .ws, .wc, .dLatched, .op(opLatched), .u, .um, .c, .firstUn, .quot, .sticky
  );

  // Square-root operand alignment assumes an even significand width
  assert property (@(posedge clk) (N % 2) == 0);

endmodule

// File: dv/tbDivSqrt.sv
// Testbench for the radix-2 SRT divide and square-root unit with N fixed at 24
// Expected results come from 64-bit integer models, so N must stay below 32
// Inputs change 1 time unit after each rising edge and outputs are read there too
module tbDivSqrt;

  localparam int N          = 24;
  localparam int HALF       = N / 2;
  localparam int LATENCY    = N + 4;
  localparam int RAND_OPS   = 300;
  localparam int EQ_OPS     = 10;
  localparam int ONE_OPS    = 10;
  localparam int SQ_OPS     = 20;
  localparam int TIMING_OPS = 4;
  localparam int HOLD_CYCLES = 6;
  localparam int NUM_OPS    = 2 * RAND_OPS + EQ_OPS + ONE_OPS + SQ_OPS + TIMING_OPS;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (N + 6) + 200;
  localparam logic [31:0] RAND_SEED = 32'h6956_950a;

  // Quotient and inexact flag of one operation
  typedef struct packed {
    logic [N:0] quot;
    logic       sticky;
  } result_t;

  logic                clk;
  logic                rstN;
  logic                start;
  divSqrtPkg::opKind_t op;
  logic [N-1:0]        x;
  logic [N-1:0]        d;
  logic                busy;
  logic                done;
  logic [N:0]          quot;
  logic                sticky;

  int cycleCount;
  int errorCount;
  int checkCount;
  int testCount;
  int lastLatency;
  bit lastBusyOk;

  divSqrtUnit #(.N(N)) dut (
    .clk, .rstN, .start, .op, .x, .d, .busy, .done, .quot, .sticky
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Ends the run if the whole test sequence overruns its cycle budget
  initial begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Simulation timed out after %0d cycles without finishing the tests", cycleCount);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////

  // Q = floor(2^N * X / D); the U1.(N-1) scale cancels between x and d
  function automatic result_t divideModel(input logic [N-1:0] xIn, input logic [N-1:0] dIn);
    longint unsigned num;
    longint unsigned den;
    longint unsigned qWide;
    result_t r;
    num = xIn;
    num = num << N;
    den = dIn;
    qWide = num / den;
    r.quot = qWide[N:0];
    r.sticky = ((num % den) != 0);
    return r;
  endfunction

  // Integer square root of R * 2^(N+2), found bit pair by bit pair
  function automatic result_t sqrtModel(input logic [N-1:0] xIn);
    longint unsigned scaled;
    longint unsigned rem;
    longint unsigned root;
    longint unsigned bitVal;
    result_t r;
    scaled = xIn;
    scaled = scaled << (N + 2);
    rem = scaled;
    root = 0;
    bitVal = 64'h1 << 62;
    while (bitVal > rem) begin
      bitVal = bitVal >> 2;
    end
    while (bitVal != 0) begin
      if (rem >= root + bitVal) begin
        rem = rem - (root + bitVal);
        root = (root >> 1) + bitVal;
      end else begin
        root = root >> 1;
      end
      bitVal = bitVal >> 2;
    end
    r.quot = root[N:0];
    // Inexact when the root squared falls short of the scaled radicand
    r.sticky = ((root * root) < scaled);
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drivers and checks
  //////////////////////////////////////////////////////////////////////

  // Issues one request and waits for done; the timeout process guards the wait
  // With disturb set, a second start with other operands is pulsed mid-run
  task automatic runOp(input divSqrtPkg::opKind_t opIn, input logic [N-1:0] xIn,
                       input logic [N-1:0] dIn, input bit disturb, output result_t got);
    int cyc;
    bit busyOk;
    if (busy) begin
      errorCount++;
      $display("Unit was still busy at time %0t when a new request was due", $time);
    end
    start = 1'b1;
    op    = opIn;
    x     = xIn;
    d     = dIn;
    // Accepting edge
    @(posedge clk);
    #1;
    start  = 1'b0;
    cyc    = 1;
    busyOk = 1'b1;
    while (!done) begin
      if (!busy) begin
        busyOk = 1'b0;
      end
      if (disturb && cyc == 5) begin
        start = 1'b1;
        op    = (opIn == divSqrtPkg::OP_DIV) ? divSqrtPkg::OP_SQRT : divSqrtPkg::OP_DIV;
        x     = ~xIn;
        d     = ~dIn;
      end else if (disturb && cyc == 6) begin
        start = 1'b0;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    // The controller is already idle in the done cycle
    if (busy) begin
      busyOk = 1'b0;
    end
    lastLatency = cyc;
    lastBusyOk  = busyOk;
    got.quot    = quot;
    got.sticky  = sticky;
  endtask

  task automatic compareResult(input divSqrtPkg::opKind_t opIn, input logic [N-1:0] xIn,
                               input logic [N-1:0] dIn, input result_t expected,
                               input result_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s x=%h d=%h expected quot=%h sticky=%b, got quot=%h sticky=%b",
               $time, (opIn == divSqrtPkg::OP_SQRT) ? "sqrt" : "div", xIn, dIn,
               expected.quot, expected.sticky, actual.quot, actual.sticky);
    end
  endtask

  task automatic reportTest(input string name, input int ops, input int errorsBefore);
    testCount++;
    $display("Test %s done: %0d operations, %0d errors", name, ops, errorCount - errorsBefore);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int k;
    int errBefore;
    logic [31:0] rnd;
    logic [31:0] tmp;
    logic [31:0] sq;
    longint unsigned wide;
    logic [N-1:0] xVal;
    logic [N-1:0] dVal;
    divSqrtPkg::opKind_t opVal;
    result_t got;
    result_t expected;

    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    lastLatency = 0;
    lastBusyOk  = 1'b1;
    rstN  = 1'b0;
    start = 1'b0;
    op    = divSqrtPkg::OP_DIV;
    x     = '0;
    d     = '0;
    rnd   = $urandom(RAND_SEED);

    // Reset state is checked in every reset cycle and two cycles after
    errBefore = errorCount;
    for (i = 0; i < 7; i++) begin
      @(posedge clk);
      #1;
      if (i == 4) begin
        rstN = 1'b1;
      end
      checkCount++;
      if (busy !== 1'b0 || done !== 1'b0) begin
        errorCount++;
        $display("[ERROR] %0t: busy=%b done=%b around reset, both expected low",
                 $time, busy, done);
      end
    end
    reportTest("reset", 0, errBefore);

    // Random division with the leading one forced on both operands
    errBefore = errorCount;
    for (i = 0; i < RAND_OPS; i++) begin
      rnd = $urandom();
      xVal = rnd[N-1:0];
      xVal[N-1] = 1'b1;
      rnd = $urandom();
      dVal = rnd[N-1:0];
      dVal[N-1] = 1'b1;
      runOp(divSqrtPkg::OP_DIV, xVal, dVal, 1'b0, got);
      compareResult(divSqrtPkg::OP_DIV, xVal, dVal, divideModel(xVal, dVal), got);
    end
    reportTest("random division", RAND_OPS, errBefore);

    // Random radicands spread over [1,4), which is [2^(N-2), 2^N) as integers
    errBefore = errorCount;
    for (i = 0; i < RAND_OPS; i++) begin
      tmp = ($urandom() % (3 << (N - 2))) + (1 << (N - 2));
      xVal = tmp[N-1:0];
      rnd = $urandom();
      dVal = rnd[N-1:0];
      runOp(divSqrtPkg::OP_SQRT, xVal, dVal, 1'b0, got);
      compareResult(divSqrtPkg::OP_SQRT, xVal, dVal, sqrtModel(xVal), got);
    end
    reportTest("random square root", RAND_OPS, errBefore);

    // Exact quotients, x equal to d gives one and a unit divisor gives 2x
    errBefore = errorCount;
    for (i = 0; i < EQ_OPS; i++) begin
      rnd = $urandom();
      dVal = rnd[N-1:0];
      dVal[N-1] = 1'b1;
      expected.quot   = (N + 1)'(1) << N;
      expected.sticky = 1'b0;
      runOp(divSqrtPkg::OP_DIV, dVal, dVal, 1'b0, got);
      compareResult(divSqrtPkg::OP_DIV, dVal, dVal, expected, got);
    end
    for (i = 0; i < ONE_OPS; i++) begin
      rnd = $urandom();
      xVal = rnd[N-1:0];
      xVal[N-1] = 1'b1;
      dVal = {1'b1, {(N - 1){1'b0}}};
      expected.quot   = {xVal, 1'b0};
      expected.sticky = 1'b0;
      runOp(divSqrtPkg::OP_DIV, xVal, dVal, 1'b0, got);
      compareResult(divSqrtPkg::OP_DIV, xVal, dVal, expected, got);
    end
    // A radicand m*m has the exact root m * 2^(HALF+1) on the result grid
    for (i = 0; i < SQ_OPS; i++) begin
      if (i == 0) begin
        tmp = 1 << (HALF - 1);
      end else if (i == 1) begin
        tmp = (1 << HALF) - 1;
      end else begin
        tmp = (1 << (HALF - 1)) + ($urandom() % (1 << (HALF - 1)));
      end
      sq = tmp * tmp;
      xVal = sq[N-1:0];
      wide = tmp;
      wide = wide << (HALF + 1);
      expected.quot   = wide[N:0];
      expected.sticky = 1'b0;
      runOp(divSqrtPkg::OP_SQRT, xVal, '0, 1'b0, got);
      compareResult(divSqrtPkg::OP_SQRT, xVal, '0, expected, got);
    end
    reportTest("exact results", EQ_OPS + ONE_OPS + SQ_OPS, errBefore);

    // Latency, busy window, ignored start and result hold after done
    errBefore = errorCount;
    for (i = 0; i < TIMING_OPS; i++) begin
      opVal = (i % 2 == 0) ? divSqrtPkg::OP_DIV : divSqrtPkg::OP_SQRT;
      rnd = $urandom();
      xVal = rnd[N-1:0];
      xVal[N-1] = 1'b1;
      rnd = $urandom();
      dVal = rnd[N-1:0];
      dVal[N-1] = 1'b1;
      expected = (opVal == divSqrtPkg::OP_SQRT) ? sqrtModel(xVal) : divideModel(xVal, dVal);
      runOp(opVal, xVal, dVal, 1'b1, got);
      compareResult(opVal, xVal, dVal, expected, got);
      checkCount++;
      if (lastLatency != LATENCY) begin
        errorCount++;
        $display("[ERROR] %0t: done came in cycle %0d after the accepting edge, expected %0d",
                 $time, lastLatency, LATENCY);
      end
      checkCount++;
      if (!lastBusyOk) begin
        errorCount++;
        $display("[ERROR] %0t: busy was not high for exactly the running cycles", $time);
      end
      // Inputs wander while idle, the result must not move
      for (k = 0; k < HOLD_CYCLES; k++) begin
        @(posedge clk);
        #1;
        rnd = $urandom();
        x  = rnd[N-1:0];
        d  = rnd[N+7:8];
        op = rnd[31] ? divSqrtPkg::OP_SQRT : divSqrtPkg::OP_DIV;
        checkCount++;
        if (quot !== expected.quot || sticky !== expected.sticky) begin
          errorCount++;
          $display("[ERROR] %0t: result moved while idle, quot=%h sticky=%b expected %h %b",
                   $time, quot, sticky, expected.quot, expected.sticky);
        end
      end
    end
    reportTest("timing and hold", TIMING_OPS, errBefore);

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: src.f
source/divSqrtPkg.sv
source/divSqrtCtrl.sv
source/divSqrtIter.sv
source/divSqrtOtf.sv
source/divSqrtPostproc.sv
source/divSqrtUnit.sv
dv/tbDivSqrt.sv
